// ==== include/lp2_macros.svh ====
// width and depth definitions for the LPDDR2 command encoder
//   chip select count, row/column/bank address widths
//   command/address word width, mode register field width
//   command buffer depth

`ifndef LP2_MACROS_SVH
`define LP2_MACROS_SVH

// memory geometry
`define LP2_NUM_CHIP   2
`define LP2_ROW_W      15
`define LP2_COL_W      12
`define LP2_BA_W       3

// command/address bus, one DDR word per clock
`define LP2_CA_W       20
`define LP2_MR_W       8     // mode register address and opcode

// encoded command buffer
`define LP2_FIFO_DEPTH 4

`endif

// ==== rtl/lp2_pkg.sv ====
// shared types for the LPDDR2 command encoder
//   command enum
//   row, column and mode register layouts of the CA word
//   CA word union over the three layouts and a raw view

`include "lp2_macros.svh"

package lp2_pkg;

    typedef enum logic [3:0] {
        act, pre, pre_all, wr, rd, ref_all, ref_bank, mrw, mrr, bst
    } lp2_cmd_e;

    ////////////////////////////////////////////////////////////////////////////
    // CA word layouts, msb first
    ////////////////////////////////////////////////////////////////////////////

    // activate
    typedef struct packed {
        logic [1:0] row_14_13;
        logic [7:0] row_7_0;
        logic [2:0] bank;
        logic [2:0] row_12_10;
        logic [1:0] row_9_8;
        logic [1:0] code;       // always 10
    } lp2_ca_row_t;

    // read / write, also carries the precharge bank
    typedef struct packed {
        logic [8:0] col_11_3;
        logic       ap;
        logic [2:0] bank;
        logic [1:0] col_2_1;
        logic       zero;
        logic [3:0] code;
    } lp2_ca_col_t;

    // mode register write / read
    typedef struct packed {
        logic [1:0] ma_7_6;
        logic [7:0] op;
        logic [5:0] ma_5_0;
        logic [3:0] code;
    } lp2_ca_mr_t;

    typedef union packed {
        lp2_ca_row_t            row;
        lp2_ca_col_t            col;
        lp2_ca_mr_t             mr;
        logic [`LP2_CA_W-1:0]   raw;
    } lp2_ca_word_u;

endpackage

// ==== rtl/lp2_cmd_if.sv ====
// encoded command channel
//   valid/ready handshake, per chip select and CA word
//   src and dst modports

`timescale 1ns/10ps
`include "lp2_macros.svh"

interface lp2_cmd_if;
    import lp2_pkg::*;

    logic                       valid;
    logic                       ready;
    logic [`LP2_NUM_CHIP-1:0]   cs_n;   // active low, one per chip
    lp2_ca_word_u               ca;

    modport src (
        output valid,
        output cs_n,
        output ca,
        input  ready
    );

    modport dst (
        input  valid,
        input  cs_n,
        input  ca,
        output ready
    );

endinterface

// ==== rtl/lp2_cmd_encoder.sv ====
// LPDDR2 command encoder
//   request handshake, command decode into the CA word layouts
//   one-entry output slot held under back-pressure

`timescale 1ns/10ps
`include "lp2_macros.svh"

module lp2_cmd_encoder (
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  lp2_pkg::lp2_cmd_e           req_cmd,
    input  logic [`LP2_NUM_CHIP-1:0]    req_chip,
    input  logic [`LP2_BA_W-1:0]        req_bank,
    input  logic [`LP2_ROW_W-1:0]       req_row,
    input  logic [`LP2_COL_W-1:0]       req_col,
    input  logic                        req_auto_precharge,
    input  logic [`LP2_MR_W-1:0]        req_mr_addr,
    input  logic [`LP2_MR_W-1:0]        req_mr_opcode,
    lp2_cmd_if.src                      cmd_out
);
    import lp2_pkg::*;

    lp2_ca_word_u               enc_ca;
    logic                       req_take;
    logic                       slot_valid;
    logic [`LP2_NUM_CHIP-1:0]   slot_cs_n;
    lp2_ca_word_u               slot_ca;

    ////////////////////////////////////////////////////////////////////////////
    // command decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        enc_ca = '0;            // unlisted bits stay zero
        case (req_cmd)
            act:
            begin
                enc_ca.row.row_14_13 = req_row[14:13];
                enc_ca.row.row_7_0   = req_row[7:0];
                enc_ca.row.bank      = req_bank;
                enc_ca.row.row_12_10 = req_row[12:10];
                enc_ca.row.row_9_8   = req_row[9:8];
                enc_ca.row.code      = 2'b10;
            end
            pre:
            begin
                enc_ca.col.bank = req_bank;  // no row bits on precharge
                enc_ca.col.code = 4'b1011;
            end
            pre_all:
            begin
                enc_ca.col.zero = 1'b1;      // all-bank flag in bit 4
                enc_ca.col.code = 4'b1011;
            end
            wr, rd:
            begin
                enc_ca.col.col_11_3 = req_col[11:3];
                enc_ca.col.ap       = req_auto_precharge;
                enc_ca.col.bank     = req_bank;
                enc_ca.col.col_2_1  = req_col[2:1];
                enc_ca.col.code     = (req_cmd == wr) ? 4'b0001 : 4'b0101;
            end
            ref_all:  enc_ca.raw[3:0] = 4'b1100;
            ref_bank: enc_ca.raw[3:0] = 4'b0100;
            mrw, mrr:
            begin
                enc_ca.mr.ma_7_6 = req_mr_addr[7:6];
                enc_ca.mr.ma_5_0 = req_mr_addr[5:0];
                if (req_cmd == mrw)
                begin
                    enc_ca.mr.op   = req_mr_opcode;
                    enc_ca.mr.code = 4'b0000;
                end
                else
                begin
                    enc_ca.mr.code = 4'b1000;  // opcode field zero on read
                end
            end
            bst:      enc_ca.raw[3:0] = 4'b0011;
            default:  enc_ca = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // output slot
    ////////////////////////////////////////////////////////////////////////////

    assign req_ready = ~slot_valid | cmd_out.ready;   // empty or draining now
    assign req_take  = req_valid & req_ready;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            slot_valid <= 1'b0;
        end
        else if (req_take)
        begin
            slot_valid <= 1'b1;
        end
        else if (cmd_out.ready)
        begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge ctl_clk)
    begin
        if (req_take)
        begin
            slot_ca   <= enc_ca;
            slot_cs_n <= ~req_chip;
        end
    end

    assign cmd_out.valid = slot_valid;
    assign cmd_out.cs_n  = slot_cs_n;
    assign cmd_out.ca    = slot_ca;

    // a command with no chip selected would be silently lost downstream
    a_req_chip_nonzero: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        req_take |-> (req_chip != '0)
    );

endmodule

// ==== rtl/lp2_cmd_fifo.sv ====
// encoded command queue
//   circular store with read/write pointers and entry count
//   first-word-fall-through head, push and pop in the same cycle

`timescale 1ns/10ps
`include "lp2_macros.svh"

module lp2_cmd_fifo (
    input  logic    ctl_clk,
    input  logic    ctl_reset_n,
    lp2_cmd_if.dst  cmd_in,
    lp2_cmd_if.src  cmd_out
);
    import lp2_pkg::*;

    localparam int PTR_W = $clog2(`LP2_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`LP2_FIFO_DEPTH + 1);

    lp2_ca_word_u               ca_mem   [`LP2_FIFO_DEPTH];
    logic [`LP2_NUM_CHIP-1:0]   cs_n_mem [`LP2_FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       push;
    logic                       pop;

    assign cmd_in.ready  = (count != CNT_W'(`LP2_FIFO_DEPTH));
    assign cmd_out.valid = (count != '0);
    assign cmd_out.ca    = ca_mem[rd_ptr];      // head shown without delay
    assign cmd_out.cs_n  = cs_n_mem[rd_ptr];

    assign push = cmd_in.valid & cmd_in.ready;
    assign pop  = cmd_out.valid & cmd_out.ready;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(`LP2_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(`LP2_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge ctl_clk)
    begin
        if (push)
        begin
            ca_mem[wr_ptr]   <= cmd_in.ca;
            cs_n_mem[wr_ptr] <= cmd_in.cs_n;
        end
    end

    a_count_in_range: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        count <= CNT_W'(`LP2_FIFO_DEPTH)
    );

    // waiting head must not move or vanish until the driver takes it
    a_head_stable: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        (cmd_out.valid && !cmd_out.ready) |=>
            (cmd_out.valid && $stable(cmd_out.ca) && $stable(cmd_out.cs_n))
    );

endmodule

// ==== rtl/lp2_afi_driver.sv ====
// AFI command driver
//   takes the queue head while calibration is good
//   registered cs_n / addr, no-operation in idle cycles

`timescale 1ns/10ps
`include "lp2_macros.svh"

module lp2_afi_driver (
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  logic                        ctl_cal_success,
    lp2_cmd_if.dst                      cmd_in,
    output logic [`LP2_NUM_CHIP-1:0]    afi_cs_n,
    output logic [`LP2_CA_W-1:0]        afi_addr
);

    logic issue;

    assign cmd_in.ready = ctl_cal_success;          // hold everything until calibrated
    assign issue        = cmd_in.valid & cmd_in.ready;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            afi_cs_n <= '1;
            afi_addr <= '0;
        end
        else if (issue)
        begin
            afi_cs_n <= cmd_in.cs_n;
            afi_addr <= cmd_in.ca.raw;
        end
        else
        begin
            afi_cs_n <= '1;                         // nop
            afi_addr <= '0;
        end
    end

    // no chip may be selected in the cycle after an uncalibrated edge
    a_no_cmd_uncal: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        !ctl_cal_success |=> (afi_cs_n == '1)
    );

endmodule

// ==== rtl/lp2_addr_cmd_top.sv ====
// LPDDR2 address/command top level
//   encoder -> command queue -> AFI driver
//   plain request and AFI ports

`timescale 1ns/10ps
`include "lp2_macros.svh"

module lp2_addr_cmd_top (
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  logic                        ctl_cal_success,

    // request port
    input  logic                        req_valid,
    output logic                        req_ready,
    input  lp2_pkg::lp2_cmd_e           req_cmd,
    input  logic [`LP2_NUM_CHIP-1:0]    req_chip,
    input  logic [`LP2_BA_W-1:0]        req_bank,
    input  logic [`LP2_ROW_W-1:0]       req_row,
    input  logic [`LP2_COL_W-1:0]       req_col,
    input  logic                        req_auto_precharge,
    input  logic [`LP2_MR_W-1:0]        req_mr_addr,
    input  logic [`LP2_MR_W-1:0]        req_mr_opcode,

    // AFI
    output logic [`LP2_NUM_CHIP-1:0]    afi_cs_n,
    output logic [`LP2_CA_W-1:0]        afi_addr
);

    lp2_cmd_if cmd_enc_if ();
    lp2_cmd_if cmd_q_if ();

    lp2_cmd_encoder u_cmd_encoder (
        .ctl_clk            (ctl_clk),
        .ctl_reset_n        (ctl_reset_n),
        .req_valid          (req_valid),
        .req_ready          (req_ready),
        .req_cmd            (req_cmd),
        .req_chip           (req_chip),
        .req_bank           (req_bank),
        .req_row            (req_row),
        .req_col            (req_col),
        .req_auto_precharge (req_auto_precharge),
        .req_mr_addr        (req_mr_addr),
        .req_mr_opcode      (req_mr_opcode),
        .cmd_out            (cmd_enc_if.src)
    );

    lp2_cmd_fifo u_cmd_fifo (
        .ctl_clk            (ctl_clk),
        .ctl_reset_n        (ctl_reset_n),
        .cmd_in             (cmd_enc_if.dst),
        .cmd_out            (cmd_q_if.src)
    );

    lp2_afi_driver u_afi_driver (
        .ctl_clk            (ctl_clk),
        .ctl_reset_n        (ctl_reset_n),
        .ctl_cal_success    (ctl_cal_success),
        .cmd_in             (cmd_q_if.dst),
        .afi_cs_n           (afi_cs_n),
        .afi_addr           (afi_addr)
    );

endmodule

// ==== tb/tb_lp2_addr_cmd.sv ====
// testbench for the LPDDR2 address/command top level
//   clock, reset, seeded random request and calibration stimulus
//   reference encoder model and expected command queue
//   output checks at mid-cycle, watchdog

`timescale 1ns/10ps
`include "lp2_macros.svh"

module tb_lp2_addr_cmd;
    import lp2_pkg::*;

    localparam int N_REQ      = 600;
    localparam int MAX_FLIGHT = `LP2_FIFO_DEPTH + 1;
    localparam int TIMEOUT_NS = N_REQ * 40 + 2000;

    logic                               ctl_clk;
    logic                               ctl_reset_n;
    logic                               ctl_cal_success;
    logic                               req_valid;
    logic                               req_ready;
    lp2_cmd_e                           req_cmd;
    logic [`LP2_NUM_CHIP-1:0]           req_chip;
    logic [`LP2_BA_W-1:0]               req_bank;
    logic [`LP2_ROW_W-1:0]              req_row;
    logic [`LP2_COL_W-1:0]              req_col;
    logic                               req_auto_precharge;
    logic [`LP2_MR_W-1:0]               req_mr_addr;
    logic [`LP2_MR_W-1:0]               req_mr_opcode;
    logic [`LP2_NUM_CHIP-1:0]           afi_cs_n;
    logic [`LP2_CA_W-1:0]               afi_addr;

    logic [`LP2_NUM_CHIP+`LP2_CA_W-1:0] exp_q [$];     // {cs_n, ca}
    logic [`LP2_NUM_CHIP+`LP2_CA_W-1:0] exp_word;
    int unsigned                        lcg_state = 72073;
    int                                 accepted  = 0;
    int                                 cmd_seen [10];
    bit                                 last_take = 1'b0;
    bit                                 cal_at_edge = 1'b0;
    bit                                 cal_level;
    int                                 drain_cycles;

    lp2_addr_cmd_top dut_i (.*);

    initial
    begin
        ctl_clk = 1'b0;
        forever #2 ctl_clk = ~ctl_clk;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // CA word straight from the LPDDR2 command table
    function automatic logic [`LP2_CA_W-1:0] expected_word(
        input lp2_cmd_e cmd, input logic [2:0] ba, input logic [14:0] row,
        input logic [11:0] col, input logic ap, input logic [7:0] ma, input logic [7:0] op);
        case (cmd)
            act:      return {row[14:13], row[7:0], ba, row[12:10], row[9:8], 2'b10};
            pre:      return {10'b0, ba, 3'b0, 4'b1011};
            pre_all:  return {15'b0, 1'b1, 4'b1011};
            wr:       return {col[11:3], ap, ba, col[2:1], 1'b0, 4'b0001};
            rd:       return {col[11:3], ap, ba, col[2:1], 1'b0, 4'b0101};
            ref_all:  return {16'b0, 4'b1100};
            ref_bank: return {16'b0, 4'b0100};
            mrw:      return {ma[7:6], op, ma[5:0], 4'b0000};
            mrr:      return {ma[7:6], 8'b0, ma[5:0], 4'b1000};
            default:  return {16'b0, 4'b0011};             // bst
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic pick_request();
        req_cmd            = lp2_cmd_e'(4'(next_rand() % 10));
        req_bank           = 3'(next_rand());
        req_row            = 15'(next_rand());
        req_col            = 12'(next_rand());
        req_auto_precharge = 1'(next_rand());
        req_mr_addr        = 8'(next_rand());
        req_mr_opcode      = 8'(next_rand());
        if (req_cmd == pre_all || req_cmd == ref_all)
            req_chip = 2'(1 + next_rand() % 3);     // any nonzero mask
        else
            req_chip = 2'(1 << (next_rand() % 2));  // one-hot
    endtask

    // one clock of stimulus, a held request stays until taken
    task automatic drive_cycle(input bit want_valid, input bit cal);
        @(posedge ctl_clk);
        #1;
        ctl_cal_success = cal;
        if (!req_valid || last_take)
        begin
            if (want_valid)
                pick_request();
            req_valid = want_valid;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor, mid-cycle so inputs and outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge ctl_clk)
    begin
        if (ctl_reset_n)
        begin
            if (!cal_at_edge)
                assert (afi_cs_n == '1)
                    else report_error("command issued while calibration was low");
            if (afi_cs_n != '1)
            begin
                assert (exp_q.size() > 0)
                    else report_error("command on the AFI with none outstanding");
                exp_word = exp_q.pop_front();
                assert ({afi_cs_n, afi_addr} == exp_word)
                    else report_error($sformatf("got cs_n %b addr %h, expected cs_n %b addr %h",
                        afi_cs_n, afi_addr, exp_word[21:20], exp_word[19:0]));
            end
            else
            begin
                assert (afi_addr == '0)
                    else report_error($sformatf("nop with addr %h", afi_addr));
            end
            last_take = req_valid && req_ready;     // handshake at the coming edge
            if (last_take)
            begin
                exp_q.push_back({~req_chip, expected_word(req_cmd, req_bank, req_row,
                    req_col, req_auto_precharge, req_mr_addr, req_mr_opcode)});
                accepted++;
                cmd_seen[int'(req_cmd)]++;
                assert (exp_q.size() <= MAX_FLIGHT)
                    else report_error("more requests accepted than the design can hold");
            end
            cal_at_edge = ctl_cal_success;
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("error: simulation timed out before all requests were issued");
        $display("TEST FAILED");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        ctl_reset_n        = 1'b0;
        ctl_cal_success    = 1'b0;
        req_valid          = 1'b0;
        req_cmd            = act;
        req_chip           = 2'b01;
        req_bank           = '0;
        req_row            = '0;
        req_col            = '0;
        req_auto_precharge = 1'b0;
        req_mr_addr        = '0;
        req_mr_opcode      = '0;
        foreach (cmd_seen[i])
            cmd_seen[i] = 0;
        repeat (5) @(posedge ctl_clk);
        #1 ctl_reset_n = 1'b1;

        // uncalibrated, requests pile up until back-pressure
        repeat (12) drive_cycle(1'b1, 1'b0);
        assert (req_ready == 1'b0)
            else report_error("req_ready still high with the buffer full");
        assert (exp_q.size() == MAX_FLIGHT)
            else report_error($sformatf("%0d requests held, expected %0d",
                exp_q.size(), MAX_FLIGHT));
        while (exp_q.size() != 0 || req_valid)
            drive_cycle(1'b0, 1'b1);

        // random gaps and calibration toggling
        cal_level = 1'b1;
        while (accepted < N_REQ)
        begin
            if (next_rand() % 8 == 0)
                cal_level = ~cal_level;
            drive_cycle(next_rand() % 10 < 7, cal_level);
        end

        drain_cycles = 0;
        while ((exp_q.size() != 0 || req_valid) && drain_cycles < 200)
        begin
            drive_cycle(1'b0, 1'b1);
            drain_cycles++;
        end
        repeat (4) drive_cycle(1'b0, 1'b1);     // catch stray commands
        foreach (cmd_seen[i])
            assert (cmd_seen[i] > 0)
                else report_error($sformatf("command type %0d never requested", i));

        if (exp_q.size() == 0 && !req_valid)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("error: %0d accepted requests never reached the AFI", exp_q.size());
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== compile.f ====
+incdir+include
rtl/lp2_pkg.sv
rtl/lp2_cmd_if.sv
rtl/lp2_cmd_encoder.sv
rtl/lp2_cmd_fifo.sv
rtl/lp2_afi_driver.sv
rtl/lp2_addr_cmd_top.sv
tb/tb_lp2_addr_cmd.sv

// ==== Makefile ====
# Verilator build and run for the LPDDR2 address/command encoder

SIM  := obj_dir/Vtb_lp2_addr_cmd
SRCS := $(shell grep -v '^+' compile.f) include/lp2_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) compile.f
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_lp2_addr_cmd -o Vtb_lp2_addr_cmd

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
